/* verilog/boot_rom.hex */
// One 32-bit word per line in hex, word index 0 to 15 from the top
00000013
deadbeef
01234567
89abcdef
a5a5a5a5
5a5a5a5a
0f0f0f0f
f0f0f0f0
13579bdf
2468ace0
c001d00d
7e57c0de
00ff00ff
ff00ff00
feedface
12345678

/* all.f */
common/bus_pkg.sv
common/soc_map_pkg.sv
common/wb_if.sv
interconnect/wb_arbiter.sv
interconnect/wb_decoder.sv
verilog/boot_rom.sv
verilog/scratch_ram.sv
uart/uart_tx.sv
verilog/helix_periph_top.sv
testbench/tb_clk_gen.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f all.f --top-module tb_top -o sim_tb_top || exit 1
out=$(./obj_dir/sim_tb_top)
echo "$out"
echo "$out" | grep -qxF "Done: no errors" && exit 0 || exit 1

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import bus_pkg::*;
  import soc_map_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic              clk;
  logic              rst_n;
  logic              h_cyc  [2];
  logic              h_stb  [2];
  logic              h_we   [2];
  logic [ADDR_W-1:0] h_adr  [2];
  logic [DATA_W-1:0] h_wdat [2];
  logic [SEL_W-1:0]  h_sel  [2];
  logic [DATA_W-1:0] h_rdat [2];
  logic              h_ack  [2];
  logic              h_err  [2];
  logic              uart_tx;

  logic [DATA_W-1:0] rom_image [ROM_WORDS];
  integer            seed = 32'hecc3_b9d6;
  int                cycle_cnt = 0;
  int                err_cnt = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  tb_clk_gen u_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  helix_periph_top u_helix_periph_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .host0_cyc_i (h_cyc[0]),
    .host0_stb_i (h_stb[0]),
    .host0_we_i  (h_we[0]),
    .host0_adr_i (h_adr[0]),
    .host0_dat_i (h_wdat[0]),
    .host0_sel_i (h_sel[0]),
    .host0_dat_o (h_rdat[0]),
    .host0_ack_o (h_ack[0]),
    .host0_err_o (h_err[0]),
    .host1_cyc_i (h_cyc[1]),
    .host1_stb_i (h_stb[1]),
    .host1_we_i  (h_we[1]),
    .host1_adr_i (h_adr[1]),
    .host1_dat_i (h_wdat[1]),
    .host1_sel_i (h_sel[1]),
    .host1_dat_o (h_rdat[1]),
    .host1_ack_o (h_ack[1]),
    .host1_err_o (h_err[1]),
    .uart_tx_o   (uart_tx)
  );

  // Cycle stamp for ordering acks and serial bits
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Expected ROM contents
  initial begin
    $readmemh("verilog/boot_rom.hex", rom_image);
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [ADDR_W-1:0] word_addr(input logic [3:0] region, input int ofs);
    return {region, 26'(ofs), 2'b00};
  endfunction

  // Lanes with sel set take the new byte
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                   input logic [DATA_W-1:0] new_w,
                                                   input logic [SEL_W-1:0] sel);
    logic [DATA_W-1:0] res;
    int                b;
    res = old_w;
    for (b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_word(input string tname, input string what,
                            input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("error %s %s: expected %h, actual %h", tname, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string tname, input int err_start);
    tests_run++;
    if (err_cnt == err_start) begin
      $display("%s: pass", tname);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d errors", tname, err_cnt - err_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus host driver
  //////////////////////////////////////////////////

  // One classic cycle on host h
  // resp packs {ack, err}
  task automatic bus_xfer(input int h, input logic we, input logic [ADDR_W-1:0] adr,
                          input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel,
                          output logic [DATA_W-1:0] rdat, output logic [1:0] resp,
                          output int done_cyc);
    int   waited;
    logic done;
    waited   = 0;
    done     = 1'b0;
    rdat     = '0;
    resp     = 2'b00;
    done_cyc = 0;
    @(negedge clk);
    h_cyc[h]  = 1'b1;
    h_stb[h]  = 1'b1;
    h_we[h]   = we;
    h_adr[h]  = adr;
    h_wdat[h] = wdat;
    h_sel[h]  = sel;
    while (!done && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
      if (h_ack[h] || h_err[h]) begin
        done     = 1'b1;
        resp     = {h_ack[h], h_err[h]};
        rdat     = h_rdat[h];
        done_cyc = cycle_cnt;
      end
    end
    if (!done) begin
      $display("host %0d: no ack or err within %0d cycles at address %h", h, TIMEOUT, adr);
      err_cnt++;
    end
    // Drop the request on the response edge
    h_cyc[h] = 1'b0;
    h_stb[h] = 1'b0;
    h_we[h]  = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Serial line monitor
  //////////////////////////////////////////////////

  // Samples each bit at its middle
  // stop_cyc stamps the stop bit sample
  task automatic serial_rx(output logic [7:0] data, output logic stop_bit, output int stop_cyc);
    int   waited;
    int   k;
    logic seen;
    waited   = 0;
    seen     = 1'b0;
    data     = '0;
    stop_bit = 1'b0;
    stop_cyc = 0;
    while (!seen && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
      seen = (uart_tx === 1'b0);
    end
    if (!seen) begin
      $display("serial monitor: no start bit on tx within %0d cycles", TIMEOUT);
      err_cnt++;
    end else begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        $display("serial monitor: start bit did not stay low to its middle");
        err_cnt++;
      end
      for (k = 0; k < 8; k++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[k] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      stop_bit = uart_tx;
      stop_cyc = cycle_cnt;
    end
  endtask

  // Poll status until the transmitter reports idle
  task automatic wait_uart_idle(input string tname);
    logic [DATA_W-1:0] rd;
    logic [1:0]        resp;
    int                cyc;
    int                tries;
    logic              idle;
    tries = 0;
    idle  = 1'b0;
    while (!idle && tries < 40) begin
      bus_xfer(0, 1'b0, word_addr(REGION_UART, UART_STATUS_OFS), '0, '1, rd, resp, cyc);
      tries++;
      idle = (rd == '0) && (resp == 2'b10);
    end
    if (!idle) begin
      $display("%s: UART status never returned to idle", tname);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic rom_read();
    logic [DATA_W-1:0] rd;
    logic [1:0]        resp;
    int                cyc;
    int                i;
    int                err_start;
    err_start = err_cnt;
    // One extra read past the end checks aliasing
    for (i = 0; i <= ROM_WORDS; i++) begin
      bus_xfer(0, 1'b0, word_addr(REGION_ROM, i), '0, '1, rd, resp, cyc);
      check_word("rom_read", "resp", 2'b10, resp);
      check_word("rom_read", "data", rom_image[i % ROM_WORDS], rd);
    end
    report_test("rom_read", err_start);
  endtask

  task automatic ram_write_read();
    int                offs [4] = '{3, 17, 40, 63};
    logic [SEL_W-1:0]  sels [4] = '{4'b0001, 4'b0100, 4'b1010, 4'b0110};
    logic [DATA_W-1:0] model [4];
    logic [DATA_W-1:0] wd;
    logic [DATA_W-1:0] rd;
    logic [1:0]        resp;
    int                cyc;
    int                i;
    int                err_start;
    err_start = err_cnt;
    // Full words first
    for (i = 0; i < 4; i++) begin
      model[i] = $random(seed);
      bus_xfer(1, 1'b1, word_addr(REGION_RAM, offs[i]), model[i], '1, rd, resp, cyc);
      check_word("ram_write_read", "write resp", 2'b10, resp);
    end
    // Then single lanes over the top
    for (i = 0; i < 4; i++) begin
      wd = $random(seed);
      bus_xfer(1, 1'b1, word_addr(REGION_RAM, offs[i]), wd, sels[i], rd, resp, cyc);
      check_word("ram_write_read", "byte write resp", 2'b10, resp);
      model[i] = merge_bytes(model[i], wd, sels[i]);
    end
    for (i = 0; i < 4; i++) begin
      bus_xfer(1, 1'b0, word_addr(REGION_RAM, offs[i]), '0, '1, rd, resp, cyc);
      check_word("ram_write_read", "read resp", 2'b10, resp);
      check_word("ram_write_read", "read data", model[i], rd);
    end
    report_test("ram_write_read", err_start);
  endtask

  task automatic bus_errors();
    logic [DATA_W-1:0] wd;
    logic [DATA_W-1:0] rd;
    logic [1:0]        resp;
    int                cyc;
    int                err_start;
    err_start = err_cnt;
    // Region 3 is unmapped
    bus_xfer(0, 1'b0, word_addr(4'd3, 4), '0, '1, rd, resp, cyc);
    check_word("bus_errors", "unmapped resp", 2'b01, resp);
    // ROM write goes through host 1
    bus_xfer(1, 1'b1, word_addr(REGION_ROM, 2), 32'h1234_5678, '1, rd, resp, cyc);
    check_word("bus_errors", "rom write resp", 2'b01, resp);
    // Bus still usable afterwards
    wd = $random(seed);
    bus_xfer(0, 1'b1, word_addr(REGION_RAM, 5), wd, '1, rd, resp, cyc);
    check_word("bus_errors", "ram write resp", 2'b10, resp);
    bus_xfer(0, 1'b0, word_addr(REGION_RAM, 5), '0, '1, rd, resp, cyc);
    check_word("bus_errors", "ram read resp", 2'b10, resp);
    check_word("bus_errors", "ram read data", wd, rd);
    report_test("bus_errors", err_start);
  endtask

  task automatic arbitration();
    logic [DATA_W-1:0] d0;
    logic [DATA_W-1:0] d1;
    logic [DATA_W-1:0] rd0;
    logic [DATA_W-1:0] rd1;
    logic [1:0]        resp0;
    logic [1:0]        resp1;
    int                cyc0;
    int                cyc1;
    int                pass;
    int                err_start;
    err_start = err_cnt;
    for (pass = 0; pass < 2; pass++) begin
      d0 = $random(seed);
      d1 = $random(seed);
      // Both hosts request on the same falling edge
      fork
        bus_xfer(0, 1'b1, word_addr(REGION_RAM, 20 + 2*pass), d0, '1, rd0, resp0, cyc0);
        bus_xfer(1, 1'b1, word_addr(REGION_RAM, 21 + 2*pass), d1, '1, rd1, resp1, cyc1);
      join
      check_word("arbitration", "host 0 resp", 2'b10, resp0);
      check_word("arbitration", "host 1 resp", 2'b10, resp1);
      if (pass == 0 && cyc0 > cyc1) begin
        $display("arbitration: host 1 was served before host 0 in the first pair");
        err_cnt++;
      end
      if (pass == 1 && cyc1 > cyc0) begin
        $display("arbitration: host 0 was served before host 1 in the second pair");
        err_cnt++;
      end
      bus_xfer(0, 1'b0, word_addr(REGION_RAM, 20 + 2*pass), '0, '1, rd0, resp0, cyc0);
      check_word("arbitration", "host 0 read back", d0, rd0);
      bus_xfer(1, 1'b0, word_addr(REGION_RAM, 21 + 2*pass), '0, '1, rd1, resp1, cyc1);
      check_word("arbitration", "host 1 read back", d1, rd1);
    end
    report_test("arbitration", err_start);
  endtask

  task automatic uart_frame();
    logic [7:0]        tx_byte;
    logic [7:0]        rx_byte;
    logic              stop_bit;
    int                stop_cyc;
    logic [DATA_W-1:0] rd;
    logic [1:0]        resp;
    int                cyc;
    int                err_start;
    err_start = err_cnt;
    tx_byte = 8'($random(seed));
    fork
      begin
        bus_xfer(0, 1'b1, word_addr(REGION_UART, UART_DATA_OFS), {24'h0, tx_byte}, '1,
                 rd, resp, cyc);
        check_word("uart_frame", "write resp", 2'b10, resp);
        // Frame still on the line here
        bus_xfer(0, 1'b0, word_addr(REGION_UART, UART_STATUS_OFS), '0, '1, rd, resp, cyc);
        check_word("uart_frame", "busy status", 32'h1, rd);
      end
      serial_rx(rx_byte, stop_bit, stop_cyc);
    join
    check_word("uart_frame", "serial byte", {24'h0, tx_byte}, {24'h0, rx_byte});
    check_word("uart_frame", "stop bit", 32'h1, {31'h0, stop_bit});
    wait_uart_idle("uart_frame");
    bus_xfer(0, 1'b0, word_addr(REGION_UART, UART_DATA_OFS), '0, '1, rd, resp, cyc);
    check_word("uart_frame", "data readback", {24'h0, tx_byte}, rd);
    report_test("uart_frame", err_start);
  endtask

  task automatic uart_backpressure();
    logic [7:0]        b0;
    logic [7:0]        b1;
    logic [7:0]        r0;
    logic [7:0]        r1;
    logic              s0;
    logic              s1;
    int                sc0;
    int                sc1;
    int                cyc1;
    int                cyc2;
    logic [DATA_W-1:0] rd;
    logic [1:0]        resp;
    int                err_start;
    err_start = err_cnt;
    b0 = 8'($random(seed));
    b1 = 8'($random(seed));
    fork
      begin
        bus_xfer(0, 1'b1, word_addr(REGION_UART, UART_DATA_OFS), {24'h0, b0}, '1,
                 rd, resp, cyc1);
        check_word("uart_backpressure", "first resp", 2'b10, resp);
        bus_xfer(0, 1'b1, word_addr(REGION_UART, UART_DATA_OFS), {24'h0, b1}, '1,
                 rd, resp, cyc2);
        check_word("uart_backpressure", "second resp", 2'b10, resp);
      end
      begin
        serial_rx(r0, s0, sc0);
        serial_rx(r1, s1, sc1);
      end
    join
    // Stop bit began half a bit before its sample
    if (cyc2 <= sc0 - CLKS_PER_BIT / 2) begin
      $display("uart_backpressure: second write acked before the first stop bit began");
      err_cnt++;
    end
    check_word("uart_backpressure", "first byte", {24'h0, b0}, {24'h0, r0});
    check_word("uart_backpressure", "second byte", {24'h0, b1}, {24'h0, r1});
    check_word("uart_backpressure", "stop bits", 32'h3, {30'h0, s0, s1});
    wait_uart_idle("uart_backpressure");
    report_test("uart_backpressure", err_start);
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin
    int waited;
    int h;
    waited = 0;
    for (h = 0; h < 2; h++) begin
      h_cyc[h]  = 1'b0;
      h_stb[h]  = 1'b0;
      h_we[h]   = 1'b0;
      h_adr[h]  = '0;
      h_wdat[h] = '0;
      h_sel[h]  = '0;
    end
    while (rst_n !== 1'b1 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      err_cnt++;
    end
    rom_read();
    ram_write_read();
    bus_errors();
    arbitration();
    uart_frame();
    uart_backpressure();
    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held for 3 rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/helix_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module helix_periph_top
  import bus_pkg::*;
(
  input wire                clk_i,
  input wire                rst_n_i,

  // Host 0, core data side
  input wire                host0_cyc_i,
  input wire                host0_stb_i,
  input wire                host0_we_i,
  input wire bus_addr_u     host0_adr_i,
  input wire [DATA_W-1:0]   host0_dat_i,
  input wire [SEL_W-1:0]    host0_sel_i,
  output logic [DATA_W-1:0] host0_dat_o,
  output logic              host0_ack_o,
  output logic              host0_err_o,

  // Host 1, external host
  input wire                host1_cyc_i,
  input wire                host1_stb_i,
  input wire                host1_we_i,
  input wire bus_addr_u     host1_adr_i,
  input wire [DATA_W-1:0]   host1_dat_i,
  input wire [SEL_W-1:0]    host1_sel_i,
  output logic [DATA_W-1:0] host1_dat_o,
  output logic              host1_ack_o,
  output logic              host1_err_o,

  // Serial line
  output logic              uart_tx_o
);

  wb_if host0_bus ();
  wb_if host1_bus ();
  wb_if shared_bus ();
  wb_if rom_bus ();
  wb_if ram_bus ();
  wb_if uart_bus ();

  //////////////////////////////////////////////////
  // Host ports onto the bus
  //////////////////////////////////////////////////

  assign host0_bus.cyc   = host0_cyc_i;
  assign host0_bus.stb   = host0_stb_i;
  assign host0_bus.we    = host0_we_i;
  assign host0_bus.adr   = host0_adr_i;
  assign host0_bus.dat_w = host0_dat_i;
  assign host0_bus.sel   = host0_sel_i;
  assign host0_dat_o     = host0_bus.dat_r;
  assign host0_ack_o     = host0_bus.ack;
  assign host0_err_o     = host0_bus.err;

  assign host1_bus.cyc   = host1_cyc_i;
  assign host1_bus.stb   = host1_stb_i;
  assign host1_bus.we    = host1_we_i;
  assign host1_bus.adr   = host1_adr_i;
  assign host1_bus.dat_w = host1_dat_i;
  assign host1_bus.sel   = host1_sel_i;
  assign host1_dat_o     = host1_bus.dat_r;
  assign host1_ack_o     = host1_bus.ack;
  assign host1_err_o     = host1_bus.err;

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  wb_arbiter u_wb_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .host0_bus  (host0_bus),
    .host1_bus  (host1_bus),
    .shared_bus (shared_bus)
  );

  wb_decoder u_wb_decoder (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .shared_bus (shared_bus),
    .rom_bus    (rom_bus),
    .ram_bus    (ram_bus),
    .uart_bus   (uart_bus)
  );

  //////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////

  boot_rom u_boot_rom (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rom_bus (rom_bus)
  );

  scratch_ram u_scratch_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .ram_bus (ram_bus)
  );

  uart_tx u_uart_tx (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .uart_bus (uart_bus),
    .tx_o     (uart_tx_o)
  );

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input wire   clk_i,
  input wire   rst_n_i,
  wb_if.target uart_bus,
  output logic tx_o
);

  logic                       req;
  logic                       reg_is_data;
  logic                       reg_is_status;
  logic                       data_wr;
  logic                       accept;
  logic                       bit_end;
  logic                       busy_q;
  logic [7:0]                 data_q;
  logic [UART_FRAME_BITS-1:0] shift_q;
  logic [UART_CNT_W-1:0]      clk_cnt_q;
  logic [UART_BIT_W-1:0]      bit_cnt_q;

  //////////////////////////////////////////////////
  // Register access
  //////////////////////////////////////////////////

  assign req           = uart_bus.cyc & uart_bus.stb & ~uart_bus.ack;
  // Low offset bit picks the register
  assign reg_is_data   = uart_bus.adr.split.offset[0] == 1'(UART_DATA_OFS);
  assign reg_is_status = uart_bus.adr.split.offset[0] == 1'(UART_STATUS_OFS);
  assign data_wr       = uart_bus.we & reg_is_data;
  // Data write stalls while a frame is on the line
  assign accept        = req & ~(data_wr & busy_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      uart_bus.ack <= 1'b0;
      data_q       <= 8'h00;
    end else begin
      uart_bus.ack <= accept;
      if (accept && data_wr) begin
        data_q <= uart_bus.dat_w[7:0];
      end
    end
  end

  // Read data, busy flag in bit 0 of status
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (reg_is_status) begin
        uart_bus.dat_r <= {{(DATA_W-1){1'b0}}, busy_q};
      end else begin
        uart_bus.dat_r <= {{(DATA_W-8){1'b0}}, data_q};
      end
    end
  end

  assign uart_bus.err = 1'b0;

  //////////////////////////////////////////////////
  // Serializer
  //////////////////////////////////////////////////

  // Last clock of the current bit
  assign bit_end = clk_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      shift_q   <= '1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (accept && data_wr) begin
      // Stop, data LSB first, start
      busy_q    <= 1'b1;
      shift_q   <= {1'b1, uart_bus.dat_w[7:0], 1'b0};
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (busy_q) begin
      if (bit_end) begin
        clk_cnt_q <= '0;
        // Ones fill in behind, line idles high
        shift_q   <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (bit_cnt_q == UART_BIT_W'(UART_FRAME_BITS - 1)) begin
          busy_q <= 1'b0;
        end
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

  assign tx_o = shift_q[0];

endmodule

`default_nettype wire

/* verilog/scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module scratch_ram
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input wire   clk_i,
  input wire   rst_n_i,
  wb_if.target ram_bus
);

  logic [DATA_W-1:0]    ram_mem [RAM_WORDS];
  logic [RAM_IDX_W-1:0] idx;
  logic                 req;

  // Offset wraps at RAM depth
  assign idx = ram_bus.adr.split.offset[RAM_IDX_W-1:0];
  assign req = ram_bus.cyc & ram_bus.stb & ~ram_bus.ack;

  // Registered ack, one cycle after stb
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ram_bus.ack <= 1'b0;
    end else begin
      ram_bus.ack <= req;
    end
  end

  // Byte lane writes
  // Read returns the word before the write
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (ram_bus.we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (ram_bus.sel[b]) begin
            ram_mem[idx][8*b +: 8] <= ram_bus.dat_w[8*b +: 8];
          end
        end
      end
      ram_bus.dat_r <= ram_mem[idx];
    end
  end

  assign ram_bus.err = 1'b0;

endmodule

`default_nettype wire

/* verilog/boot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_rom
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input wire   clk_i,
  input wire   rst_n_i,
  wb_if.target rom_bus
);

  logic [DATA_W-1:0]    rom_mem [ROM_WORDS];
  logic [ROM_IDX_W-1:0] idx;
  logic                 req;

  // Image loaded at elaboration
  initial begin
    $readmemh(ROM_FILE, rom_mem);
  end

  // Offset wraps at ROM depth
  assign idx = rom_bus.adr.split.offset[ROM_IDX_W-1:0];
  // New request, not the ack cycle
  assign req = rom_bus.cyc & rom_bus.stb & ~rom_bus.ack;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rom_bus.ack <= 1'b0;
    end else begin
      rom_bus.ack <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      rom_bus.dat_r <= rom_mem[idx];
    end
  end

  // Decoder filters writes
  assign rom_bus.err = 1'b0;

endmodule

`default_nettype wire

/* interconnect/wb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_decoder
  import soc_map_pkg::*;
(
  input wire   clk_i,
  input wire   rst_n_i,
  wb_if.target shared_bus,
  wb_if.host   rom_bus,
  wb_if.host   ram_bus,
  wb_if.host   uart_bus
);

  logic [3:0] region;
  logic       rom_sel;
  logic       ram_sel;
  logic       uart_sel;
  logic       bad_req;
  logic       err_q;

  // Target select from the region field
  // ROM writes select nothing
  assign region   = shared_bus.adr.split.region;
  assign rom_sel  = (region == REGION_ROM) & ~shared_bus.we;
  assign ram_sel  = (region == REGION_RAM);
  assign uart_sel = (region == REGION_UART);
  assign bad_req  = ~(rom_sel | ram_sel | uart_sel);

  // Error response, one cycle after stb
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= shared_bus.cyc & shared_bus.stb & bad_req & ~err_q;
    end
  end

  // Only the selected target sees the cycle
  assign rom_bus.cyc  = shared_bus.cyc & rom_sel;
  assign rom_bus.stb  = shared_bus.stb & rom_sel;
  assign ram_bus.cyc  = shared_bus.cyc & ram_sel;
  assign ram_bus.stb  = shared_bus.stb & ram_sel;
  assign uart_bus.cyc = shared_bus.cyc & uart_sel;
  assign uart_bus.stb = shared_bus.stb & uart_sel;

  // Payload fields fan out unchanged
  assign rom_bus.we     = shared_bus.we;
  assign rom_bus.adr    = shared_bus.adr;
  assign rom_bus.dat_w  = shared_bus.dat_w;
  assign rom_bus.sel    = shared_bus.sel;
  assign ram_bus.we     = shared_bus.we;
  assign ram_bus.adr    = shared_bus.adr;
  assign ram_bus.dat_w  = shared_bus.dat_w;
  assign ram_bus.sel    = shared_bus.sel;
  assign uart_bus.we    = shared_bus.we;
  assign uart_bus.adr   = shared_bus.adr;
  assign uart_bus.dat_w = shared_bus.dat_w;
  assign uart_bus.sel   = shared_bus.sel;

  // Response mux, address is held until the response
  assign shared_bus.ack = (rom_sel & rom_bus.ack) | (ram_sel & ram_bus.ack)
                        | (uart_sel & uart_bus.ack);
  assign shared_bus.err = err_q | (rom_sel & rom_bus.err) | (ram_sel & ram_bus.err)
                        | (uart_sel & uart_bus.err);
  assign shared_bus.dat_r = ram_sel  ? ram_bus.dat_r :
                            uart_sel ? uart_bus.dat_r : rom_bus.dat_r;

endmodule

`default_nettype wire

/* interconnect/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input wire   clk_i,
  input wire   rst_n_i,
  wb_if.target host0_bus,
  wb_if.target host1_bus,
  wb_if.host   shared_bus
);

  logic grant_valid_q;
  logic grant_id_q;
  logic last_win_q;
  logic req0;
  logic req1;
  logic pick_id;
  logic granted_cyc;

  // Raw requests from both hosts
  assign req0 = host0_bus.cyc & host0_bus.stb;
  assign req1 = host1_bus.cyc & host1_bus.stb;

  // Contested request goes to the loser of the last contest
  always_comb begin
    if (req0 && req1) begin
      pick_id = ~last_win_q;
    end else begin
      pick_id = req1;
    end
  end

  // Owner still holding its cycle
  assign granted_cyc = grant_id_q ? host1_bus.cyc : host0_bus.cyc;

  //////////////////////////////////////////////////
  // Grant register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      grant_valid_q <= 1'b0;
      grant_id_q    <= 1'b0;
      // Host 0 preferred out of reset
      last_win_q    <= 1'b1;
    end else if (!grant_valid_q) begin
      if (req0 || req1) begin
        grant_valid_q <= 1'b1;
        grant_id_q    <= pick_id;
      end
      if (req0 && req1) begin
        last_win_q <= pick_id;
      end
    end else if (shared_bus.ack || shared_bus.err || !granted_cyc) begin
      // Free the bus the cycle after the response
      grant_valid_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Request forwarding
  //////////////////////////////////////////////////

  assign shared_bus.cyc   = grant_valid_q & granted_cyc;
  assign shared_bus.stb   = grant_valid_q & (grant_id_q ? host1_bus.stb : host0_bus.stb);
  assign shared_bus.we    = grant_id_q ? host1_bus.we    : host0_bus.we;
  assign shared_bus.adr   = grant_id_q ? host1_bus.adr   : host0_bus.adr;
  assign shared_bus.dat_w = grant_id_q ? host1_bus.dat_w : host0_bus.dat_w;
  assign shared_bus.sel   = grant_id_q ? host1_bus.sel   : host0_bus.sel;

  // Responses only reach the owner
  assign host0_bus.ack   = grant_valid_q & ~grant_id_q & shared_bus.ack;
  assign host0_bus.err   = grant_valid_q & ~grant_id_q & shared_bus.err;
  assign host0_bus.dat_r = (grant_valid_q && !grant_id_q) ? shared_bus.dat_r : '0;
  assign host1_bus.ack   = grant_valid_q & grant_id_q & shared_bus.ack;
  assign host1_bus.err   = grant_valid_q & grant_id_q & shared_bus.err;
  assign host1_bus.dat_r = (grant_valid_q && grant_id_q) ? shared_bus.dat_r : '0;

endmodule

`default_nettype wire

/* common/wb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface wb_if
  import bus_pkg::*;
();

  // Request, driven by the host
  logic              cyc;
  logic              stb;
  logic              we;
  bus_addr_u         adr;
  logic [DATA_W-1:0] dat_w;
  bus_sel_t          sel;

  // Response, driven by the target
  // ack and err never high together
  logic [DATA_W-1:0] dat_r;
  logic              ack;
  logic              err;

  modport host (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack, err
  );

  modport target (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

/* common/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

  // Region codes in address bits 31..28
  localparam logic [3:0] REGION_ROM  = 4'd0;
  localparam logic [3:0] REGION_RAM  = 4'd1;
  localparam logic [3:0] REGION_UART = 4'd2;

  // Memory depths in words
  localparam int ROM_WORDS = 16;
  localparam int RAM_WORDS = 64;

  // Word index widths, upper offset bits alias
  localparam int ROM_IDX_W = 4;
  localparam int RAM_IDX_W = 6;

  // UART register word offsets
  localparam int UART_DATA_OFS   = 0;
  localparam int UART_STATUS_OFS = 1;

  // Serial timing, 8N1 frame
  localparam int CLKS_PER_BIT    = 8;
  localparam int UART_FRAME_BITS = 10;
  localparam int UART_CNT_W      = $clog2(CLKS_PER_BIT);
  localparam int UART_BIT_W      = $clog2(UART_FRAME_BITS);

  // Boot image, path from the run directory
  localparam string ROM_FILE = "verilog/boot_rom.hex";

endpackage

`default_nettype wire

/* common/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // One select bit per byte lane
  typedef logic [SEL_W-1:0] bus_sel_t;

  // Split view of a byte address
  typedef struct packed {
    logic [3:0]  region;
    logic [25:0] offset;
    logic [1:0]  lane;
  } bus_addr_split_t;

  // Same word seen flat or split
  // Decoder looks at region, targets at offset
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    bus_addr_split_t   split;
  } bus_addr_u;

endpackage

`default_nettype wire
